// ==== Bender.yml ====
package:
  name: memsys

sources:
  - src/memsys_pkg.sv
  - src/memsys_if.sv
  - src/bus_router.sv
  - src/icache.sv
  - src/inst_mem.sv
  - src/data_mem.sv
  - src/perf_counter.sv
  - src/byte_fifo.sv
  - src/uart_tx.sv
  - src/memsys_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/memsys_tb.sv

// ==== bench/memsys_tb_tasks.svh ====
`ifndef MEMSYS_TB_TASKS_SVH
`define MEMSYS_TB_TASKS_SVH

	task automatic check_word(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected)
			abort_run($sformatf("CHECK FAILED %s: expected 0x%08h, got 0x%08h",
				name, expected, actual));
	endtask

	task automatic check_byte(input string name, input logic [7:0] expected,
			input logic [7:0] actual);
		if (actual !== expected)
			abort_run($sformatf("CHECK FAILED %s: expected 0x%02h, got 0x%02h",
				name, expected, actual));
	endtask

	task automatic preload_word(input logic [WORD_AW-1:0] addr, input logic [31:0] value);
		@(negedge clk_cpu);
		load_valid = 1'b1;
		load_addr  = addr;
		load_data  = value;
		@(negedge clk_cpu);
		load_valid = 1'b0;
	endtask

	// ########################################################################
	// CPU bus
	// ########################################################################

	task automatic issue_request(input logic [31:0] addr, input logic is_write,
			input logic [31:0] wdata, input logic [3:0] strobe);
		@(negedge clk_cpu);
		rw_address    = addr;
		write_data    = wdata;
		write_strobe  = strobe;
		read_request  = !is_write;
		write_request = is_write;
		@(negedge clk_cpu);
		read_request  = 1'b0;
		write_request = 1'b0;
	endtask

	// Latency counts from the falling edge that drove the request.
	task automatic wait_response(input logic is_write, output int lat);
		lat = 1;
		while ((is_write ? write_response : read_response) !== 1'b1 && lat < RESP_LIMIT) begin
			@(negedge clk_cpu);
			lat++;
		end
		if ((is_write ? write_response : read_response) !== 1'b1)
			abort_run($sformatf("No %s arrived within %0d cycles of the request",
				is_write ? "write_response" : "read_response", RESP_LIMIT));
	endtask

	task automatic expect_no_response(input logic [31:0] addr, input logic is_write);
		issue_request(addr, is_write, 32'h0, 4'hF);
		repeat (10) begin
			@(negedge clk_cpu);
			if (read_response !== 1'b0 || write_response !== 1'b0)
				abort_run("A request made while enb was low got a response");
		end
	endtask

	// Samples each bit in its middle, starting from the falling start edge.
	task automatic capture_byte(output logic [7:0] value);
		int idle_cycles;
		idle_cycles = 0;
		while (tx_data !== 1'b0) begin
			@(negedge clk_cpu);
			idle_cycles++;
			if (idle_cycles > 40 * CLKS_PER_BIT)
				abort_run("No UART start bit appeared on tx_data");
		end
		repeat (CLKS_PER_BIT / 2) @(negedge clk_cpu);
		if (tx_data !== 1'b0)
			abort_run("The UART start bit on tx_data ended too early");
		for (int i = 0; i < 8; i++) begin
			repeat (CLKS_PER_BIT) @(negedge clk_cpu);
			value[i] = tx_data;
		end
		repeat (CLKS_PER_BIT) @(negedge clk_cpu);
		if (tx_data !== 1'b1)
			abort_run("The UART stop bit on tx_data was not high");
	endtask

`endif

// ==== bench/memsys_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module memsys_tb import memsys_pkg::*; ();

	localparam int NUM_TESTS       = 5;
	localparam int WATCHDOG_CYCLES = NUM_TESTS * 2000;
	localparam int HALF_PERIOD     = 4;
	localparam int RESP_LIMIT      = 40;	// Longest wait for a bus response, in cycles.
	localparam int RANDOM_WRITES   = 48;

	logic               clk_cpu = 1'b0;
	logic               rst;
	logic               enb;
	logic               load_valid;
	logic [WORD_AW-1:0] load_addr;
	logic [31:0]        load_data;
	logic [31:0]        rw_address;
	logic               read_request;
	logic [31:0]        write_data;
	logic [3:0]         write_strobe;
	logic               write_request;
	logic               report;
	logic [31:0]        read_data;
	logic               read_response;
	logic               write_response;
	logic               tx_data;

	integer seed = 63;

	logic [31:0]         inst_model [MEM_WORDS];
	logic [31:0]         data_model [MEM_WORDS];
	logic [IC_TAG_W-1:0] tag_model [IC_LINES];
	logic [IC_LINES-1:0] valid_model;
	logic [15:0]         exp_miss;
	logic [15:0]         exp_rd;
	logic [15:0]         exp_wr;

	memsys_top dut (.*);

	always #HALF_PERIOD clk_cpu = ~clk_cpu;

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TEST RESULT: FAIL");
		$fatal(1);
	endtask

	`include "memsys_tb_tasks.svh"

	task automatic apply_reset();
		rst = 1'b1;
		repeat (4) @(negedge clk_cpu);
		rst = 1'b0;
		valid_model = '0;
		for (int i = 0; i < IC_LINES; i++)
			tag_model[i] = '0;	// Don't care while the line is invalid.
		exp_miss = '0;
		exp_rd   = '0;
		exp_wr   = '0;
	endtask

	// ########################################################################
	// Reference model
	// ########################################################################

	// Returns 1 on a predicted hit; on a miss the line is taken over by the new tag.
	function automatic bit cache_lookup(input logic [31:0] addr);
		logic [IC_IDX_W-1:0] idx;
		logic [IC_TAG_W-1:0] tag;
		idx = addr[7:4];
		tag = addr[9:8];
		if (valid_model[idx] && tag_model[idx] == tag)
			return 1'b1;
		valid_model[idx] = 1'b1;
		tag_model[idx]   = tag;
		exp_miss         = exp_miss + 16'd1;
		return 1'b0;
	endfunction

	task automatic fetch_and_compare(input logic [31:0] addr);
		int lat;
		bit hit;
		hit = cache_lookup(addr);
		issue_request(addr, 1'b0, '0, '0);
		wait_response(1'b0, lat);
		check_word("read_data", inst_model[addr[9:2]], read_data);
		if (hit)
			check_word("read_response latency", 32'd2, lat);
		else if (lat <= 2)
			abort_run($sformatf("Read of 0x%08h was answered in %0d cycles on a cache miss",
				addr, lat));
	endtask

	task automatic read_back(input logic [31:0] addr);
		int lat;
		issue_request(addr, 1'b0, '0, '0);
		wait_response(1'b0, lat);
		exp_rd = exp_rd + 16'd1;
		check_word("read_data", data_model[addr[9:2]], read_data);
		check_word("read_response latency", 32'd2, lat);
	endtask

	task automatic store_word(input logic [31:0] addr, input logic [31:0] wdata,
			input logic [3:0] strobe);
		int lat;
		issue_request(addr, 1'b1, wdata, strobe);
		wait_response(1'b1, lat);
		check_word("write_response latency", 32'd2, lat);
		if (addr > END_INST) begin	// Writes below the data region are dropped.
			exp_wr = exp_wr + 16'd1;
			for (int b = 0; b < 4; b++)
				if (strobe[b])
					data_model[addr[9:2]][8*b +: 8] = wdata[8*b +: 8];
		end
	endtask

	// ########################################################################
	// Tests
	// ########################################################################

	task automatic preload_and_fetch();
		for (int i = 0; i < MEM_WORDS; i++) begin
			inst_model[i] = $random(seed);
			preload_word(WORD_AW'(i), inst_model[i]);
		end
		@(negedge clk_cpu);
		enb = 1'b1;
		for (int i = 0; i < MEM_WORDS; i++)
			fetch_and_compare(32'(i) << 2);
	endtask

	task automatic cache_hit_timing();
		logic [31:0] addr;
		apply_reset();
		fetch_and_compare(32'h0000_0120);	// Fresh cache, so a miss.
		fetch_and_compare(32'h0000_0120);
		fetch_and_compare(32'h0000_012C);
		for (int n = 0; n < 32; n++) begin
			addr = $random(seed) & 32'h0000_033C;	// Four lines, all four tags.
			fetch_and_compare(addr);
		end
	endtask

	task automatic strobe_writes();
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0]  strobe;
		for (int i = 0; i < MEM_WORDS; i++)
			store_word(DATA_BASE + (32'(i) << 2), $random(seed), 4'hF);
		for (int n = 0; n < RANDOM_WRITES; n++) begin
			addr   = DATA_BASE + ($random(seed) & 32'h0000_0FFC);
			wdata  = $random(seed);
			strobe = 4'($random(seed));
			store_word(addr, wdata, strobe);
			read_back(addr);
		end
		addr = $random(seed) & 32'h0000_03FC;
		store_word(addr, $random(seed), 4'hF);
		read_back(addr | DATA_BASE);	// Same data word as the dropped write.
	endtask

	task automatic enable_gating();
		logic [IC_TAG_W-1:0] tag;
		logic [WORD_AW-1:0]  word;
		@(negedge clk_cpu);
		enb = 1'b0;
		expect_no_response(DATA_BASE + 32'h40, 1'b0);
		expect_no_response(DATA_BASE + 32'h40, 1'b1);
		tag  = tag_model[0] + 1'b1;	// Line 0 does not hold this tag.
		word = {tag, 4'd0, 2'd1};
		inst_model[word] = $random(seed);
		preload_word(word, inst_model[word]);
		@(negedge clk_cpu);
		enb = 1'b1;
		fetch_and_compare(32'(word) << 2);
	endtask

	task automatic counter_report();
		logic [8*REPORT_BYTES-1:0] first;
		logic [7:0]                expected;
		logic [7:0]                value;
		first = {exp_miss, exp_rd, exp_wr};
		@(negedge clk_cpu);
		report = 1'b1;
		repeat (2) @(negedge clk_cpu);	// Second report on the next cycle.
		report = 1'b0;
		for (int i = 0; i < 2 * REPORT_BYTES; i++) begin
			expected = (i < REPORT_BYTES) ? first[8*(REPORT_BYTES-1-i) +: 8] : 8'h00;
			capture_byte(value);
			check_byte("tx_data byte", expected, value);
		end
	endtask

	initial begin
		enb           = 1'b0;
		load_valid    = 1'b0;
		load_addr     = '0;
		load_data     = '0;
		rw_address    = '0;
		read_request  = 1'b0;
		write_data    = '0;
		write_strobe  = '0;
		write_request = 1'b0;
		report        = 1'b0;
		apply_reset();
		preload_and_fetch();
		cache_hit_timing();
		strobe_writes();
		enable_gating();
		counter_report();
		$display("TEST RESULT: PASS");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_cpu);
		abort_run($sformatf("Timeout: the tests did not finish within %0d cycles",
			WATCHDOG_CYCLES));
	end

endmodule

`default_nettype wire

// ==== src/bus_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_router import memsys_pkg::*; (
	input  wire         clk_cpu,
	input  wire         rst,
	input  wire         enb,
	input  wire  [31:0] rw_address,
	input  wire         read_request,
	input  wire         write_request,
	input  wire  [31:0] write_data,
	input  wire  [3:0]  write_strobe,
	output logic [31:0] read_data,
	output logic        read_response,
	output logic        write_response,
	mem_port_if.router  inst,
	mem_port_if.router  data
);

	route_t      route;
	logic        accept;
	logic        in_inst;
	logic        op_write;
	logic        drop_ack;
	logic [31:0] addr_q;
	logic [31:0] wdata_q;
	logic [3:0]  strobe_q;

	assign accept  = enb && (read_request || write_request);
	assign in_inst = (rw_address <= END_INST);

	always_ff @(posedge clk_cpu) begin
		if (rst) begin
			route    <= ROUTE_IDLE;
			op_write <= 1'b0;
			drop_ack <= 1'b0;
		end else begin
			drop_ack <= (route == ROUTE_DROP);	// Answers a dropped write one cycle later.
			if (accept) begin
				op_write <= !read_request;
				if (read_request)
					route <= in_inst ? ROUTE_INST : ROUTE_DATA;
				else
					route <= in_inst ? ROUTE_DROP : ROUTE_DATA;
			end else begin
				route <= ROUTE_IDLE;
			end
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (accept) begin
			addr_q   <= rw_address;
			wdata_q  <= write_data;
			strobe_q <= write_strobe;
		end
	end

	// ########################################################################
	// Side requests and response merge
	// ########################################################################

	assign inst.addr   = addr_q;
	assign inst.read   = (route == ROUTE_INST);
	assign inst.write  = 1'b0;	// The cache is read only.
	assign inst.wdata  = '0;
	assign inst.strobe = '0;

	assign data.addr   = addr_q;
	assign data.read   = (route == ROUTE_DATA) && !op_write;
	assign data.write  = (route == ROUTE_DATA) && op_write;
	assign data.wdata  = wdata_q;
	assign data.strobe = strobe_q;

	assign read_data      = inst.ready ? inst.rdata : data.rdata;
	assign read_response  = inst.ready || (data.ready && !op_write);
	assign write_response = drop_ack || (data.ready && op_write);

endmodule

`default_nettype wire

// ==== src/byte_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_fifo import memsys_pkg::*; (
	input  wire        clk_cpu,
	input  wire        rst,
	input  wire        push,
	input  wire  [7:0] push_data,
	input  wire        pop,
	output logic [7:0] head,
	output logic       empty,
	output logic       full
);

	logic [7:0]         mem [FIFO_DEPTH];
	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	logic [FIFO_AW:0]   count;
	logic               do_push;
	logic               do_pop;

	assign do_push = push && !full;	// A push into a full queue is lost.
	assign do_pop  = pop && !empty;
	assign empty   = (count == '0);
	assign full    = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
	assign head    = mem[rd_ptr];

	always_ff @(posedge clk_cpu) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

endmodule

`default_nettype wire

// ==== src/data_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_mem import memsys_pkg::*; (
	input  wire        clk_cpu,
	input  wire        rst,
	mem_port_if.memory port
);

	logic [31:0]        mem [MEM_WORDS];
	logic [31:0]        offset;
	logic [WORD_AW-1:0] idx;

	assign offset = port.addr - DATA_BASE;
	assign idx    = offset[WORD_AW+1:2];	// Higher addresses alias onto the same words.

	always_ff @(posedge clk_cpu) begin
		if (port.write) begin
			for (int b = 0; b < 4; b++) begin
				if (port.strobe[b])
					mem[idx][8*b +: 8] <= port.wdata[8*b +: 8];
			end
		end
		if (port.read)
			port.rdata <= mem[idx];
	end

	always_ff @(posedge clk_cpu) begin
		if (rst)
			port.ready <= 1'b0;
		else
			port.ready <= port.read || port.write;
	end

endmodule

`default_nettype wire

// ==== src/icache.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache import memsys_pkg::*; (
	input  wire                clk_cpu,
	input  wire                rst,
	mem_port_if.memory         port,
	output logic [WORD_AW-1:0] fill_addr,
	output logic               fill_read,
	input  wire  [31:0]        fill_data,
	input  wire                fill_valid,
	output logic               miss
);

	typedef enum logic [1:0] {IC_IDLE, IC_LOOKUP, IC_FILL_REQ, IC_FILL_WAIT} ic_state_t;

	ic_state_t           state;
	logic [31:0]         req_addr;
	logic [IC_OFF_W-1:0] fill_cnt;
	logic [IC_LINES-1:0] valid;
	logic [IC_TAG_W-1:0] tag_arr [IC_LINES];
	logic [31:0]         data_arr [IC_LINES*IC_WORDS];
	logic [IC_OFF_W-1:0] req_off;
	logic [IC_IDX_W-1:0] req_idx;
	logic [IC_TAG_W-1:0] req_tag;
	logic                hit;
	logic                fill_last;

	assign req_off   = req_addr[3:2];
	assign req_idx   = req_addr[7:4];
	assign req_tag   = req_addr[9:8];
	assign hit       = valid[req_idx] && (tag_arr[req_idx] == req_tag);
	assign fill_last = (fill_cnt == IC_OFF_W'(IC_WORDS - 1));

	assign port.ready = (state == IC_LOOKUP) && hit;
	assign port.rdata = data_arr[{req_idx, req_off}];
	assign miss       = (state == IC_LOOKUP) && !hit;
	assign fill_read  = (state == IC_FILL_REQ);
	assign fill_addr  = {req_tag, req_idx, fill_cnt};	// Word index of the next line word.

	// ########################################################################
	// Lookup and line fill
	// ########################################################################

	always_ff @(posedge clk_cpu) begin
		if (rst) begin
			state    <= IC_IDLE;
			fill_cnt <= '0;
			valid    <= '0;
		end else begin
			case (state)
				IC_IDLE: begin
					if (port.read)
						state <= IC_LOOKUP;
				end
				IC_LOOKUP: begin
					fill_cnt <= '0;
					state    <= hit ? IC_IDLE : IC_FILL_REQ;
				end
				IC_FILL_REQ: begin
					state <= IC_FILL_WAIT;
				end
				IC_FILL_WAIT: begin
					if (fill_valid) begin
						fill_cnt <= fill_cnt + 1'b1;
						if (fill_last) begin
							valid[req_idx] <= 1'b1;
							state          <= IC_LOOKUP;	// Lookup again, now a hit.
						end else begin
							state <= IC_FILL_REQ;
						end
					end
				end
				default: state <= IC_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (state == IC_IDLE && port.read)
			req_addr <= port.addr;
		if (state == IC_FILL_WAIT && fill_valid) begin
			data_arr[{req_idx, fill_cnt}] <= fill_data;
			if (fill_last)
				tag_arr[req_idx] <= req_tag;
		end
	end

endmodule

`default_nettype wire

// ==== src/inst_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_mem import memsys_pkg::*; (
	input  wire                clk_cpu,
	input  wire                enb,
	input  wire                load_valid,
	input  wire  [WORD_AW-1:0] load_addr,
	input  wire  [31:0]        load_data,
	input  wire  [WORD_AW-1:0] fill_addr,
	input  wire                fill_read,
	output logic [31:0]        fill_data,
	output logic               fill_valid
);

	logic [31:0] mem [MEM_WORDS];

	// The preload port owns the memory while the CPU is held off.
	always_ff @(posedge clk_cpu) begin
		if (!enb && load_valid)
			mem[load_addr] <= load_data;
	end

	always_ff @(posedge clk_cpu) begin
		if (fill_read)
			fill_data <= mem[fill_addr];
		fill_valid <= fill_read;	// Fill data is one cycle behind the read.
	end

endmodule

`default_nettype wire

// ==== src/memsys_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface mem_port_if;

	logic [31:0] addr;
	logic        read;	// One-cycle pulse.
	logic        write;	// One-cycle pulse.
	logic [31:0] wdata;
	logic [3:0]  strobe;
	logic [31:0] rdata;	// Valid while ready is high.
	logic        ready;	// One pulse per request.

	modport router (
		output addr,
		output read,
		output write,
		output wdata,
		output strobe,
		input  rdata,
		input  ready
	);

	modport memory (
		input  addr,
		input  read,
		input  write,
		input  wdata,
		input  strobe,
		output rdata,
		output ready
	);

endinterface

`default_nettype wire

// ==== src/memsys_pkg.sv ====
`default_nettype none

package memsys_pkg;

	// ########################################################################
	// Address map
	// ########################################################################

	localparam logic [31:0] END_INST  = 32'h0000_03FC;	// Last word of the instruction region.
	localparam logic [31:0] DATA_BASE = 32'h0000_0400;
	localparam int          WORD_AW   = 8;	// Word index width of both memories.
	localparam int          MEM_WORDS = 256;

	// ########################################################################
	// Instruction cache geometry
	// ########################################################################

	localparam int IC_LINES = 16;
	localparam int IC_WORDS = 4;
	localparam int IC_OFF_W = 2;	// Address bits 3:2.
	localparam int IC_IDX_W = 4;	// Address bits 7:4.
	localparam int IC_TAG_W = 2;	// Address bits 9:8.

	// Report path and serial line.
	localparam int REPORT_BYTES = 6;
	localparam int FIFO_DEPTH   = 8;
	localparam int FIFO_AW      = 3;
	localparam int CLKS_PER_BIT = 8;
	localparam int BAUD_CNT_W   = 3;

	typedef enum logic [1:0] {ROUTE_IDLE, ROUTE_INST, ROUTE_DATA, ROUTE_DROP} route_t;

	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

endpackage

`default_nettype wire

// ==== src/memsys_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module memsys_top import memsys_pkg::*; (
	input  wire                clk_cpu,
	input  wire                rst,
	input  wire                enb,
	input  wire                load_valid,
	input  wire  [WORD_AW-1:0] load_addr,
	input  wire  [31:0]        load_data,
	input  wire  [31:0]        rw_address,
	input  wire                read_request,
	input  wire  [31:0]        write_data,
	input  wire  [3:0]         write_strobe,
	input  wire                write_request,
	input  wire                report,
	output logic [31:0]        read_data,
	output logic               read_response,
	output logic               write_response,
	output logic               tx_data
);

	mem_port_if inst_if ();
	mem_port_if data_if ();

	logic [WORD_AW-1:0] fill_addr;
	logic               fill_read;
	logic [31:0]        fill_data;
	logic               fill_valid;
	logic               ic_miss;
	logic               push;
	logic [7:0]         push_data;
	logic               full;
	logic               pop;
	logic [7:0]         head;
	logic               empty;

	// ########################################################################
	// CPU bus and memories
	// ########################################################################

	bus_router u_router (
		.clk_cpu(clk_cpu), .rst(rst), .enb(enb),
		.rw_address(rw_address), .read_request(read_request),
		.write_request(write_request), .write_data(write_data),
		.write_strobe(write_strobe), .read_data(read_data),
		.read_response(read_response), .write_response(write_response),
		.inst(inst_if), .data(data_if)
	);

	icache u_icache (
		.clk_cpu(clk_cpu), .rst(rst), .port(inst_if),
		.fill_addr(fill_addr), .fill_read(fill_read),
		.fill_data(fill_data), .fill_valid(fill_valid), .miss(ic_miss)
	);

	inst_mem u_inst_mem (
		.clk_cpu(clk_cpu), .enb(enb), .load_valid(load_valid),
		.load_addr(load_addr), .load_data(load_data),
		.fill_addr(fill_addr), .fill_read(fill_read),
		.fill_data(fill_data), .fill_valid(fill_valid)
	);

	data_mem u_data_mem (.clk_cpu(clk_cpu), .rst(rst), .port(data_if));

	// ########################################################################
	// Counter report path
	// ########################################################################

	perf_counter u_counter (
		.clk_cpu(clk_cpu), .rst(rst), .ic_miss(ic_miss),
		.data_read(data_if.read), .data_write(data_if.write),	// Taken from the bus pulses.
		.report(report), .full(full), .push(push), .push_data(push_data)
	);

	byte_fifo u_fifo (
		.clk_cpu(clk_cpu), .rst(rst), .push(push), .push_data(push_data),
		.pop(pop), .head(head), .empty(empty), .full(full)
	);

	uart_tx u_tx (
		.clk_cpu(clk_cpu), .rst(rst), .head(head), .empty(empty),
		.pop(pop), .tx_data(tx_data)
	);

endmodule

`default_nettype wire

// ==== src/perf_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module perf_counter import memsys_pkg::*; (
	input  wire        clk_cpu,
	input  wire        rst,
	input  wire        ic_miss,
	input  wire        data_read,
	input  wire        data_write,
	input  wire        report,
	input  wire        full,
	output logic       push,
	output logic [7:0] push_data
);

	logic [15:0]               miss_cnt;
	logic [15:0]               rd_cnt;
	logic [15:0]               wr_cnt;
	logic [8*REPORT_BYTES-1:0] snap;
	logic [2:0]                byte_cnt;
	logic                      busy;
	logic                      pend;
	logic                      start;

	// Saturating step; on a snapshot the count restarts with this cycle's event.
	function automatic logic [15:0] next_count(input logic [15:0] cnt, input logic ev,
			input logic clear);
		if (clear)
			return {15'b0, ev};
		if (ev && cnt != 16'hFFFF)
			return cnt + 16'd1;
		return cnt;
	endfunction

	assign start     = (report || pend) && !busy;
	assign push      = busy && !full;
	assign push_data = snap[8*REPORT_BYTES-1 -: 8];

	always_ff @(posedge clk_cpu) begin
		if (rst) begin
			miss_cnt <= '0;
			rd_cnt   <= '0;
			wr_cnt   <= '0;
			busy     <= 1'b0;
			pend     <= 1'b0;
			byte_cnt <= '0;
		end else begin
			miss_cnt <= next_count(miss_cnt, ic_miss, start);
			rd_cnt   <= next_count(rd_cnt, data_read, start);
			wr_cnt   <= next_count(wr_cnt, data_write, start);
			if (start) begin
				busy     <= 1'b1;
				pend     <= 1'b0;
				byte_cnt <= '0;
			end else begin
				if (report)
					pend <= 1'b1;	// Served once the current bytes are out.
				if (push) begin
					byte_cnt <= byte_cnt + 3'd1;
					if (byte_cnt == 3'(REPORT_BYTES - 1))
						busy <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (start)
			snap <= {miss_cnt, rd_cnt, wr_cnt};
		else if (push)
			snap <= snap << 8;
	end

endmodule

`default_nettype wire

// ==== src/uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx import memsys_pkg::*; (
	input  wire        clk_cpu,
	input  wire        rst,
	input  wire  [7:0] head,
	input  wire        empty,
	output logic       pop,
	output logic       tx_data
);

	tx_state_t             state;
	logic [BAUD_CNT_W-1:0] baud_cnt;
	logic [2:0]            bit_idx;
	logic [7:0]            shreg;
	logic                  bit_end;

	assign pop     = (state == TX_IDLE) && !empty;
	assign bit_end = (baud_cnt == BAUD_CNT_W'(CLKS_PER_BIT - 1));

	always_ff @(posedge clk_cpu) begin
		if (rst) begin
			state    <= TX_IDLE;
			baud_cnt <= '0;
			bit_idx  <= '0;
			tx_data  <= 1'b1;
		end else begin
			baud_cnt <= (state == TX_IDLE || bit_end) ? '0 : baud_cnt + 1'b1;
			case (state)
				TX_IDLE: begin
					tx_data <= 1'b1;
					if (!empty)
						state <= TX_START;
				end
				TX_START: begin
					tx_data <= 1'b0;
					bit_idx <= '0;
					if (bit_end)
						state <= TX_DATA;
				end
				TX_DATA: begin
					tx_data <= shreg[0];	// LSB first.
					if (bit_end) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= TX_STOP;
					end
				end
				TX_STOP: begin
					tx_data <= 1'b1;
					if (bit_end)
						state <= TX_IDLE;
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (pop)
			shreg <= head;
		else if (state == TX_DATA && bit_end)
			shreg <= shreg >> 1;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+bench
src/memsys_pkg.sv
src/memsys_if.sv
src/bus_router.sv
src/icache.sv
src/inst_mem.sv
src/data_mem.sv
src/perf_counter.sv
src/byte_fifo.sv
src/uart_tx.sv
src/memsys_top.sv
bench/memsys_tb.sv
